// File: mesh_top.f
src/mesh_pkg.sv
src/mesh_router.sv
src/spm_tile.sv
src/host_tile.sv
src/mesh_top.sv
verif/mesh_top_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the mesh testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f mesh_top.f --top-module mesh_top_tb -o mesh_top_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/mesh_top_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "TEST RESULT: PASS"; then
  exit 0
fi
echo "Pass line not found in simulation output"
exit 1

// File: src/host_tile.sv
// Host tile at (0,0): the only way into the mesh from outside.
// Takes one request at a time, turns it into a request flit, and hands the
// matching response back. Tile index 0 has no memory and is answered here
// with an error, without touching the network.

`timescale 1ns/1ns

module host_tile
  import mesh_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          req_valid_i,
  input  host_req_t                     req_i,
  output logic                          busy_o,
  output logic                          rsp_valid_o,
  output host_rsp_t                     rsp_o,
  input  req_flit_t [dir_west:dir_north] req_mesh_i,
  output req_flit_t [dir_west:dir_north] req_mesh_o,
  input  rsp_flit_t [dir_west:dir_north] rsp_mesh_i,
  output rsp_flit_t [dir_west:dir_north] rsp_mesh_o
);

  req_flit_t [num_ports-1:0] req_in, req_out;
  rsp_flit_t [num_ports-1:0] rsp_in, rsp_out;

  logic [tile_idx_width-1:0] tile_idx;
  logic                      accept;
  logic                      to_self;
  logic                      net_rsp;
  logic                      busy_q;
  logic                      rsp_valid_q;
  host_rsp_t                 rsp_q;

  ////////////////////
  // Request decode
  ////////////////////

  assign tile_idx = req_i.addr[addr_width-1 -: tile_idx_width];
  assign to_self  = (tile_idx == '0);
  assign accept   = req_valid_i && !busy_q;

  // Index is y*2+x, so the low bit is x and the high bit is y
  always_comb begin
    req_in[dir_west:dir_north]  = req_mesh_i;
    req_in[dir_local].hdr.valid = accept && !to_self;
    req_in[dir_local].hdr.dst_x = tile_idx[0];
    req_in[dir_local].hdr.dst_y = tile_idx[1];
    req_in[dir_local].write     = req_i.write;
    req_in[dir_local].offset    = req_i.addr[offset_width-1:0];
    req_in[dir_local].wdata     = req_i.wdata;
  end

  assign req_mesh_o = req_out[dir_west:dir_north];

  mesh_router #(
    .flit_t(req_flit_t),
    .my_x  (1'b0),
    .my_y  (1'b0)
  ) u_req_router (
    .clk_i,
    .reset_i,
    .flits_i(req_in),
    .flits_o(req_out)
  );

  // The host never sends responses into the mesh
  assign rsp_in[dir_west:dir_north] = rsp_mesh_i;
  assign rsp_in[dir_local]          = '0;
  assign rsp_mesh_o                 = rsp_out[dir_west:dir_north];

  mesh_router #(
    .flit_t(rsp_flit_t),
    .my_x  (1'b0),
    .my_y  (1'b0)
  ) u_rsp_router (
    .clk_i,
    .reset_i,
    .flits_i(rsp_in),
    .flits_o(rsp_out)
  );

  ////////////////////
  // Outstanding tracker
  ////////////////////

  assign net_rsp = rsp_out[dir_local].hdr.valid;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q      <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= (accept && to_self) || net_rsp;
      if (accept && !to_self) begin
        busy_q <= 1'b1;
      end else if (net_rsp) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && to_self) begin
      rsp_q.rdata <= '0;
      rsp_q.err   <= 1'b1;
    end else if (net_rsp) begin
      rsp_q.rdata <= rsp_out[dir_local].rdata;
      rsp_q.err   <= 1'b0;
    end
  end

  assign busy_o      = busy_q;
  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

// File: src/mesh_pkg.sv
// Shared definitions for the 2x2 tiled mesh.
// Holds the mesh size, the address layout, the router port directions,
// the flit and host port structs, and the neighbor helpers used for wiring.
// Import with a wildcard in the module header.

package mesh_pkg;

  ////////////////////
  // Mesh geometry
  ////////////////////

  localparam int mesh_dim_x = 2;
  localparam int mesh_dim_y = 2;
  localparam int num_ports  = 5;

  localparam int data_width     = 32;
  localparam int spm_words      = 256;
  localparam int offset_width   = 8;
  localparam int tile_idx_width = 2;
  localparam int addr_width     = tile_idx_width + offset_width;

  typedef logic coord_t;
  typedef logic [addr_width-1:0] addr_t;
  typedef logic [data_width-1:0] data_t;

  // North is y+1, east is x+1
  typedef enum logic [2:0] {
    dir_local = 3'd0,
    dir_north = 3'd1,
    dir_east  = 3'd2,
    dir_south = 3'd3,
    dir_west  = 3'd4
  } route_dir_e;

  ////////////////////
  // Flits and ports
  ////////////////////

  typedef struct packed {
    logic   valid;
    coord_t dst_x;
    coord_t dst_y;
  } flit_hdr_t;

  // Routers look only at hdr, so it must stay the first field
  typedef struct packed {
    flit_hdr_t                 hdr;
    logic                      write;
    logic [offset_width-1:0]   offset;
    data_t                     wdata;
  } req_flit_t;

  typedef struct packed {
    flit_hdr_t hdr;
    data_t     rdata;
  } rsp_flit_t;

  typedef struct packed {
    logic  write;
    addr_t addr;
    data_t wdata;
  } host_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } host_rsp_t;

  ////////////////////
  // Neighbor helpers
  ////////////////////

  function automatic bit is_tie_off(int x, int y, route_dir_e dir);
    case (dir)
      dir_north: return y == mesh_dim_y - 1;
      dir_east:  return x == mesh_dim_x - 1;
      dir_south: return y == 0;
      dir_west:  return x == 0;
      default:   return 1'b0;
    endcase
  endfunction

  function automatic int neighbor_x(int x, route_dir_e dir);
    case (dir)
      dir_east: return x + 1;
      dir_west: return x - 1;
      default:  return x;
    endcase
  endfunction

  function automatic int neighbor_y(int y, route_dir_e dir);
    case (dir)
      dir_north: return y + 1;
      dir_south: return y - 1;
      default:   return y;
    endcase
  endfunction

  function automatic route_dir_e opposite_dir(route_dir_e dir);
    case (dir)
      dir_north: return dir_south;
      dir_east:  return dir_west;
      dir_south: return dir_north;
      dir_west:  return dir_east;
      default:   return dir_local;
    endcase
  endfunction

endpackage

// File: src/mesh_router.sv
// Five-port XY router with registered outputs.
// The flit type is a parameter, so one module serves both the request and
// the response network. Any flit type works as long as it starts with hdr.
// There is no back-pressure, so traffic must never collide on an output.

`timescale 1ns/1ns

module mesh_router
  import mesh_pkg::*;
#(
  parameter type    flit_t = req_flit_t,
  parameter coord_t my_x   = 1'b0,
  parameter coord_t my_y   = 1'b0
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  flit_t [num_ports-1:0] flits_i,
  output flit_t [num_ports-1:0] flits_o
);

  route_dir_e [num_ports-1:0] in_dir;
  flit_t      [num_ports-1:0] flits_d;
  flit_t      [num_ports-1:0] flits_q;

  // X is corrected first, then Y
  function automatic route_dir_e xy_route(coord_t dst_x, coord_t dst_y);
    if (dst_x > my_x) begin
      return dir_east;
    end else if (dst_x < my_x) begin
      return dir_west;
    end else if (dst_y > my_y) begin
      return dir_north;
    end else if (dst_y < my_y) begin
      return dir_south;
    end
    return dir_local;
  endfunction

  ////////////////////
  // Route compute
  ////////////////////

  always_comb begin
    for (int i = 0; i < num_ports; i++) begin
      in_dir[i] = xy_route(flits_i[i].hdr.dst_x, flits_i[i].hdr.dst_y);
    end
  end

  ////////////////////
  // Output select
  ////////////////////

  // Scan from west down to local, so the lowest index that matches wins
  always_comb begin
    flits_d = flits_q;
    for (int o = 0; o < num_ports; o++) begin
      flits_d[o].hdr.valid = 1'b0;
      for (int i = num_ports - 1; i >= 0; i--) begin
        if (flits_i[i].hdr.valid && (in_dir[i] == route_dir_e'(o))) begin
          flits_d[o] = flits_i[i];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int o = 0; o < num_ports; o++) begin
        flits_q[o].hdr.valid <= 1'b0;
      end
    end else begin
      flits_q <= flits_d;
    end
  end

  assign flits_o = flits_q;

endmodule

// File: src/mesh_top.sv
// Top level of the 2x2 mesh.
// Places the host tile at (0,0) and scratchpad tiles everywhere else, then
// joins neighbors on the request and response networks. Ports that face
// off the mesh edge are tied to zero.

`timescale 1ns/1ns

module mesh_top
  import mesh_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      req_valid_i,
  input  host_req_t req_i,
  output logic      busy_o,
  output logic      rsp_valid_o,
  output host_rsp_t rsp_o
);

  req_flit_t [mesh_dim_x-1:0][mesh_dim_y-1:0][dir_west:dir_north] req_in, req_out;
  rsp_flit_t [mesh_dim_x-1:0][mesh_dim_y-1:0][dir_west:dir_north] rsp_in, rsp_out;

  ////////////////////
  // Host tile
  ////////////////////

  host_tile u_host_tile (
    .clk_i,
    .reset_i,
    .req_valid_i,
    .req_i,
    .busy_o,
    .rsp_valid_o,
    .rsp_o,
    .req_mesh_i(req_in[0][0]),
    .req_mesh_o(req_out[0][0]),
    .rsp_mesh_i(rsp_in[0][0]),
    .rsp_mesh_o(rsp_out[0][0])
  );

  ////////////////////
  // SPM tiles
  ////////////////////

  for (genvar x = 0; x < mesh_dim_x; x++) begin : gen_spm_x
    for (genvar y = 0; y < mesh_dim_y; y++) begin : gen_spm_y
      if ((x != 0) || (y != 0)) begin : gen_spm
        spm_tile #(
          .my_x(coord_t'(x)),
          .my_y(coord_t'(y))
        ) u_spm_tile (
          .clk_i,
          .reset_i,
          .req_mesh_i(req_in[x][y]),
          .req_mesh_o(req_out[x][y]),
          .rsp_mesh_i(rsp_in[x][y]),
          .rsp_mesh_o(rsp_out[x][y])
        );
      end
    end
  end

  ////////////////////
  // Mesh links
  ////////////////////

  for (genvar x = 0; x < mesh_dim_x; x++) begin : gen_x
    for (genvar y = 0; y < mesh_dim_y; y++) begin : gen_y
      for (genvar d = int'(dir_north); d <= int'(dir_west); d++) begin : gen_dir
        localparam route_dir_e dir = route_dir_e'(d);
        if (is_tie_off(x, y, dir)) begin : gen_tie_off
          assign req_in[x][y][dir] = '0;
          assign rsp_in[x][y][dir] = '0;
        end else begin : gen_link
          localparam int         xn   = neighbor_x(x, dir);
          localparam int         yn   = neighbor_y(y, dir);
          localparam route_dir_e dirn = opposite_dir(dir);
          assign req_in[x][y][dir] = req_out[xn][yn][dirn];
          assign rsp_in[x][y][dir] = rsp_out[xn][yn][dirn];
        end
      end
    end
  end

endmodule

// File: src/spm_tile.sv
// Scratchpad tile: one word memory behind a request and a response router.
// A request at the local port is served in one cycle and answered with a
// single response flit sent back to the host tile.

`timescale 1ns/1ns

module spm_tile
  import mesh_pkg::*;
#(
  parameter coord_t my_x = 1'b1,
  parameter coord_t my_y = 1'b0
) (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  req_flit_t [dir_west:dir_north] req_mesh_i,
  output req_flit_t [dir_west:dir_north] req_mesh_o,
  input  rsp_flit_t [dir_west:dir_north] rsp_mesh_i,
  output rsp_flit_t [dir_west:dir_north] rsp_mesh_o
);

  req_flit_t [num_ports-1:0] req_in, req_out;
  rsp_flit_t [num_ports-1:0] rsp_in, rsp_out;

  req_flit_t local_req;
  data_t     mem [spm_words];
  logic      rsp_valid_q;
  data_t     rdata_q;

  ////////////////////
  // Routers
  ////////////////////

  assign req_in[dir_west:dir_north] = req_mesh_i;
  assign req_in[dir_local]          = '0;
  assign req_mesh_o                 = req_out[dir_west:dir_north];

  mesh_router #(
    .flit_t(req_flit_t),
    .my_x  (my_x),
    .my_y  (my_y)
  ) u_req_router (
    .clk_i,
    .reset_i,
    .flits_i(req_in),
    .flits_o(req_out)
  );

  mesh_router #(
    .flit_t(rsp_flit_t),
    .my_x  (my_x),
    .my_y  (my_y)
  ) u_rsp_router (
    .clk_i,
    .reset_i,
    .flits_i(rsp_in),
    .flits_o(rsp_out)
  );

  assign rsp_in[dir_west:dir_north] = rsp_mesh_i;
  assign rsp_mesh_o                 = rsp_out[dir_west:dir_north];

  ////////////////////
  // Word memory
  ////////////////////

  assign local_req = req_out[dir_local];

  always_ff @(posedge clk_i) begin
    if (local_req.hdr.valid) begin
      if (local_req.write) begin
        mem[local_req.offset] <= local_req.wdata;
      end
      // Writes answer with zero data
      rdata_q <= local_req.write ? '0 : mem[local_req.offset];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= local_req.hdr.valid;
    end
  end

  // Responses always head home to the host at (0,0)
  always_comb begin
    rsp_in[dir_local]           = '0;
    rsp_in[dir_local].hdr.valid = rsp_valid_q;
    rsp_in[dir_local].rdata     = rdata_q;
  end

endmodule

// File: verif/mesh_top_tb.sv
// Directed testbench for the 2x2 mesh top level.
// Sends single word reads and writes through the host port, checks each
// response against a word model, and covers the host error path, the busy
// window and a run of pseudo-random writes.

`timescale 1ns/1ns

module mesh_top_tb
  import mesh_pkg::*;
();

  localparam int clk_period        = 4;
  localparam int reset_cycles      = 10;
  localparam int response_timeout  = 64;
  localparam int quiet_cycles      = 32;
  localparam int num_random_writes = 40;
  // Random readback also covers the 8 locations written by earlier tests
  localparam int num_transactions  = 6 + 6 + 2 + 5 + num_random_writes + 8 + num_random_writes;
  localparam int watchdog_cycles   = num_transactions * response_timeout + reset_cycles;

  logic      clk_i = 1'b0;
  logic      reset_i;
  logic      req_valid_i;
  host_req_t req_i;
  logic      busy_o;
  logic      rsp_valid_o;
  host_rsp_t rsp_o;

  // Word model over the full address, tile index in the upper bits
  data_t       model   [1 << addr_width];
  bit          written [1 << addr_width];
  logic [31:0] lfsr_state = 32'h02fd1363;

  mesh_top u_dut (
    .clk_i,
    .reset_i,
    .req_valid_i,
    .req_i,
    .busy_o,
    .rsp_valid_o,
    .rsp_o
  );

  always #(clk_period / 2) clk_i = ~clk_i;

  ////////////////////
  // Helpers
  ////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits       = {bits[30:0], lfsr_state[0]};
    end
  endtask

  function automatic addr_t make_addr(int tile, int offset);
    return {tile[tile_idx_width-1:0], offset[offset_width-1:0]};
  endfunction

  task automatic stop_with_error(input string what);
    $display("%s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_rsp(input string test, input host_rsp_t exp, input host_rsp_t act);
    if (act !== exp) begin
      stop_with_error($sformatf("ERROR %s: expected rdata %h err %b, actual rdata %h err %b",
                                test, exp.rdata, exp.err, act.rdata, act.err));
    end
  endtask

  task automatic check_data(input string test, input data_t exp, input data_t act);
    if (act !== exp) begin
      stop_with_error($sformatf("ERROR %s: expected %h, actual %h", test, exp, act));
    end
  endtask

  task automatic check_level(input string test, input logic exp, input logic act);
    if (act !== exp) begin
      stop_with_error($sformatf("ERROR %s: expected %b, actual %b", test, exp, act));
    end
  endtask

  // Starts on a falling edge, returns on the one after the accepting edge
  task automatic send_request(input logic write, input addr_t addr, input data_t wdata);
    host_req_t req;
    req.write   = write;
    req.addr    = addr;
    req.wdata   = wdata;
    req_i       = req;
    req_valid_i = 1'b1;
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  // Busy must hold until the edge that raises the response pulse
  task automatic await_response(input string test, output host_rsp_t rsp);
    int waited;
    waited = 0;
    while (!rsp_valid_o) begin
      check_level({test, " busy held"}, 1'b1, busy_o);
      if (waited == response_timeout) begin
        stop_with_error($sformatf("%s: no response came within %0d cycles",
                                  test, response_timeout));
      end
      @(negedge clk_i);
      waited++;
    end
    rsp = rsp_o;
  endtask

  // One network request from strobe to the end of its response pulse
  task automatic run_transaction(input string test, input logic write, input addr_t addr,
                                 input data_t wdata, output host_rsp_t rsp);
    send_request(write, addr, wdata);
    check_level({test, " busy set"}, 1'b1, busy_o);
    await_response(test, rsp);
    check_level({test, " busy clear"}, 1'b0, busy_o);
    @(negedge clk_i);
    check_level({test, " single pulse"}, 1'b0, rsp_valid_o);
  endtask

  task automatic write_word(input string test, input addr_t addr, input data_t wdata);
    host_rsp_t rsp;
    host_rsp_t exp;
    exp.rdata = '0;
    exp.err   = 1'b0;
    run_transaction(test, 1'b1, addr, wdata, rsp);
    check_rsp(test, exp, rsp);
    model[addr]   = wdata;
    written[addr] = 1'b1;
  endtask

  task automatic read_word(input string test, input addr_t addr);
    host_rsp_t rsp;
    run_transaction(test, 1'b0, addr, '0, rsp);
    check_data(test, model[addr], rsp.rdata);
    check_level({test, " err"}, 1'b0, rsp.err);
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic basic_write_read();
    check_level("basic idle busy", 1'b0, busy_o);
    check_level("basic idle rsp_valid", 1'b0, rsp_valid_o);
    for (int t = 1; t < 4; t++) begin
      write_word("basic write", make_addr(t, 16 + 3 * t), data_t'(32'h5a00_0000 + t));
      read_word("basic read", make_addr(t, 16 + 3 * t));
    end
  endtask

  task automatic same_offset_per_tile();
    for (int t = 1; t < 4; t++) begin
      write_word("same offset write", make_addr(t, 8'h42), data_t'(32'h1111_1111 * t));
    end
    for (int t = 1; t < 4; t++) begin
      read_word("same offset read", make_addr(t, 8'h42));
    end
  endtask

  // Index 0 is answered by the host itself, so the pulse is immediate
  task automatic host_index_error();
    host_rsp_t exp;
    exp.rdata = '0;
    exp.err   = 1'b1;
    for (int w = 0; w < 2; w++) begin
      send_request(w[0], make_addr(0, 8'h3c), 32'hdead_beef);
      check_level("host index rsp_valid", 1'b1, rsp_valid_o);
      check_rsp("host index error", exp, rsp_o);
      check_level("host index busy", 1'b0, busy_o);
      @(negedge clk_i);
      check_level("host index pulse end", 1'b0, rsp_valid_o);
      check_level("host index busy after", 1'b0, busy_o);
    end
  endtask

  task automatic busy_ignores_strobe();
    host_rsp_t rsp;
    write_word("busy setup", make_addr(3, 9), 32'h0bad_f00d);
    write_word("busy setup", make_addr(1, 5), 32'h1234_5678);
    send_request(1'b0, make_addr(1, 5), '0);
    check_level("busy during read", 1'b1, busy_o);
    // Dropped by the host, so the model keeps the old word
    send_request(1'b1, make_addr(3, 9), 32'hffff_0000);
    await_response("busy first response", rsp);
    check_data("busy first response", model[make_addr(1, 5)], rsp.rdata);
    check_level("busy first response err", 1'b0, rsp.err);
    for (int i = 0; i < quiet_cycles; i++) begin
      @(negedge clk_i);
      check_level("busy no second response", 1'b0, rsp_valid_o);
      check_level("busy stays clear", 1'b0, busy_o);
    end
    read_word("busy ignored address", make_addr(3, 9));
  endtask

  task automatic random_write_readback();
    logic [31:0] bits;
    int          tile;
    int          offset;
    addr_t       addr;
    for (int n = 0; n < num_random_writes; n++) begin
      tile = 0;
      while (tile == 0) begin
        take_bits(tile_idx_width, bits);
        tile = int'(bits[tile_idx_width-1:0]);
      end
      take_bits(offset_width, bits);
      offset = int'(bits[offset_width-1:0]);
      take_bits(data_width, bits);
      write_word("random write", make_addr(tile, offset), bits);
    end
    for (int i = 0; i < (1 << addr_width); i++) begin
      addr = addr_t'(i);
      if (written[addr]) begin
        read_word("random readback", addr);
      end
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    reset_i     = 1'b1;
    req_valid_i = 1'b0;
    req_i       = '0;
    repeat (reset_cycles) @(negedge clk_i);
    reset_i = 1'b0;

    basic_write_read();
    same_offset_per_tile();
    host_index_error();
    busy_ignores_strobe();
    random_write_readback();

    $display("TEST RESULT: PASS");
    $finish;
  end

  initial begin
    #(watchdog_cycles * clk_period);
    stop_with_error("Watchdog expired before the tests finished");
  end

endmodule
